/* Bender.yml */
package:
  name: rv_int_core

sources:
  - design/rv_pkg.sv
  - design/pipe_slice.sv
  - design/inst_fetch.sv
  - design/issue_unit.sv
  - design/alu_lane.sv
  - design/writeback_arbiter.sv
  - design/int_regfile.sv
  - design/rv_int_core.sv
  - target: test
    files:
      - test/rv_int_core_tb.sv

/* design/alu_lane.sv */
// Integer ALU lane

`timescale 1ns/1ps
`default_nettype none

module alu_lane (
    input  wire                    aclk,
    input  wire                    arst_n,
    input  wire                    req_valid,
    output logic                   req_ready,
    input  wire rv_pkg::lane_req_t req,
    output logic                   rsp_valid,
    input  wire                    rsp_ready,
    output rv_pkg::lane_rsp_t      rsp
);

    import rv_pkg::*;

    logic [4:0] shamt;
    logic [XLEN-1:0] result;
    lane_rsp_t rsp_d;

    assign shamt = req.opb[4:0];

    always_comb begin
        case (req.op)
            ALU_ADD:  result = req.opa + req.opb;
            ALU_SUB:  result = req.opa - req.opb;
            ALU_SLL:  result = req.opa << shamt;
            ALU_SLT:  result = {31'b0, $signed(req.opa) < $signed(req.opb)};
            ALU_SLTU: result = {31'b0, req.opa < req.opb};
            ALU_XOR:  result = req.opa ^ req.opb;
            ALU_SRL:  result = req.opa >> shamt;
            ALU_SRA:  result = $unsigned($signed(req.opa) >>> shamt);
            ALU_OR:   result = req.opa | req.opb;
            ALU_AND:  result = req.opa & req.opb;
            default:  result = req.opb;
        endcase
    end

    assign rsp_d.rd = req.rd;
    assign rsp_d.res = result;

    // Single result slot, refilled while it drains
    pipe_slice #(
        .payload_t (lane_rsp_t)
    ) rsp_slot_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (rsp_d),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp)
    );

endmodule

`default_nettype wire

/* design/inst_fetch.sv */
// Sequential instruction fetch, AXI4-Lite read master

`timescale 1ns/1ps
`default_nettype none

module inst_fetch #(
    parameter logic [rv_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
    input  wire                      aclk,
    input  wire                      arst_n,
    output logic                     imem_arvalid,
    input  wire                      imem_arready,
    output logic [rv_pkg::XLEN-1:0]  imem_araddr,
    output logic [2:0]               imem_arprot,
    input  wire                      imem_rvalid,
    output logic                     imem_rready,
    input  wire  [rv_pkg::ILEN-1:0]  imem_rdata,
    input  wire  [1:0]               imem_rresp,
    output logic                     inst_valid,
    input  wire                      inst_ready,
    output logic [rv_pkg::ILEN-1:0]  inst_data,
    output logic                     inst_err,
    output logic                     fetch_busy
);

    import rv_pkg::*;

    typedef enum logic [1:0] {FS_BOOT, FS_ADDR, FS_DATA, FS_HOLD} fetch_state_e;

    fetch_state_e state;
    logic [XLEN-1:0] pc;
    logic slot_in_valid;
    logic slot_in_ready;
    logic [ILEN:0] slot_in;
    logic [ILEN:0] slot_out;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FS_BOOT;
            pc <= BOOT_ADDR;
        end else begin
            case (state)
                FS_BOOT: state <= FS_ADDR;
                FS_ADDR: if (imem_arready) state <= FS_DATA;
                FS_DATA: if (imem_rvalid && imem_rready) state <= FS_HOLD;
                FS_HOLD: begin
                    // Next word once the held one is taken
                    if (inst_valid && inst_ready) begin
                        state <= FS_ADDR;
                        pc <= pc + XLEN'(4);
                    end
                end
                default: state <= FS_BOOT;
            endcase
        end
    end

    // Instruction fetch, privileged, secure
    assign imem_arprot = 3'b101;
    assign imem_arvalid = (state == FS_ADDR);
    assign imem_araddr = pc;
    assign imem_rready = (state == FS_DATA) && slot_in_ready;

    // Any response other than OKAY flags the word
    assign slot_in_valid = (state == FS_DATA) && imem_rvalid;
    assign slot_in = {imem_rresp != 2'b00, imem_rdata};

    pipe_slice #(
        .payload_t (logic [ILEN:0])
    ) inst_slot_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (slot_in_valid),
        .in_ready  (slot_in_ready),
        .in_data   (slot_in),
        .out_valid (inst_valid),
        .out_ready (inst_ready),
        .out_data  (slot_out)
    );

    assign inst_err = slot_out[ILEN];
    assign inst_data = slot_out[ILEN-1:0];
    assign fetch_busy = (state == FS_DATA) || inst_valid;

endmodule

`default_nettype wire

/* design/int_regfile.sv */
// Integer register file

`timescale 1ns/1ps
`default_nettype none

module int_regfile (
    input  wire                                   aclk,
    input  wire                                   arst_n,
    input  wire  [rv_pkg::REG_AW-1:0]             rs1_addr,
    output logic [rv_pkg::XLEN-1:0]               rs1_val,
    input  wire  [rv_pkg::REG_AW-1:0]             rs2_addr,
    output logic [rv_pkg::XLEN-1:0]               rs2_val,
    input  wire                                   rd_wr,
    input  wire  [rv_pkg::REG_AW-1:0]             rd_addr,
    input  wire  [rv_pkg::XLEN-1:0]               rd_val,
    output logic [rv_pkg::REG_NB*rv_pkg::XLEN-1:0] dbg_regs
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [REG_NB];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_NB; i++) regs[i] <= '0;
        end else if (rd_wr && rd_addr != '0) begin
            regs[rd_addr] <= rd_val;
        end
    end

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    // Flat debug view, x0 in the low word
    always_comb begin
        for (int i = 0; i < REG_NB; i++) dbg_regs[i*XLEN +: XLEN] = regs[i];
    end

endmodule

`default_nettype wire

/* design/issue_unit.sv */
// Decode, scoreboard and lane dispatch

`timescale 1ns/1ps
`default_nettype none

module issue_unit #(
    parameter int NB_LANE = 3
) (
    input  wire                                aclk,
    input  wire                                arst_n,
    input  wire                                inst_valid,
    output logic                               inst_ready,
    input  wire  [rv_pkg::ILEN-1:0]            inst_data,
    input  wire                                inst_err,
    output logic [rv_pkg::REG_AW-1:0]          rs1_addr,
    input  wire  [rv_pkg::XLEN-1:0]            rs1_val,
    output logic [rv_pkg::REG_AW-1:0]          rs2_addr,
    input  wire  [rv_pkg::XLEN-1:0]            rs2_val,
    output logic [NB_LANE-1:0]                 lane_req_valid,
    input  wire  [NB_LANE-1:0]                 lane_req_ready,
    output rv_pkg::lane_req_t [NB_LANE-1:0]    lane_req,
    input  wire                                wb_done,
    input  wire  [rv_pkg::REG_AW-1:0]          wb_addr,
    output logic                               issue_busy,
    output logic                               illegal,
    output logic                               bus_err
);

    import rv_pkg::*;

    localparam int PW = (NB_LANE > 1) ? $clog2(NB_LANE) : 1;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [REG_AW-1:0] rd;
    logic is_op, is_imm, is_lui;
    logic drop, hazard, issue_ok, dispatch;
    logic [REG_NB-1:0] pend;
    logic [PW-1:0] ptr;
    lane_req_t req_d;

    function automatic alu_op_e alu_op(input logic [2:0] f3, input logic alt, input logic reg_op);
        alu_op_e op;
        case (f3)
            3'b000: op = (reg_op && alt) ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = alt ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    ////////////////////
    // Decode
    ////////////////////

    assign opcode = inst_data[6:0];
    assign rd = inst_data[11:7];
    assign funct3 = inst_data[14:12];
    assign rs1_addr = inst_data[19:15];
    assign rs2_addr = inst_data[24:20];

    assign is_op = (opcode == OPC_OP);
    assign is_imm = (opcode == OPC_OP_IMM);
    assign is_lui = (opcode == OPC_LUI);

    always_comb begin
        req_d.op = ALU_ADD;
        req_d.rd = rd;
        req_d.opa = rs1_val;
        req_d.opb = rs2_val;
        if (is_op) begin
            req_d.op = alu_op(funct3, inst_data[30], 1'b1);
        end else if (is_imm) begin
            req_d.op = alu_op(funct3, inst_data[30], 1'b0);
            req_d.opb = {{20{inst_data[31]}}, inst_data[31:20]};
        end else if (is_lui) begin
            req_d.op = ALU_PASS_B;
            req_d.opb = {inst_data[31:12], 12'h000};
        end
    end

    ////////////////////
    // Hazards and dispatch
    ////////////////////

    // Bus errors win, the word itself is meaningless then
    assign drop = inst_err || !(is_op || is_imm || is_lui);
    assign hazard = ((is_op || is_imm) && pend[rs1_addr]) || (is_op && pend[rs2_addr]) || pend[rd];
    assign issue_ok = inst_valid && !drop && !hazard;
    assign dispatch = issue_ok && lane_req_ready[ptr];
    assign inst_ready = drop || (!hazard && lane_req_ready[ptr]);

    always_comb begin
        for (int i = 0; i < NB_LANE; i++) begin
            lane_req_valid[i] = issue_ok && (ptr == PW'(i));
            lane_req[i] = req_d;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pend <= '0;
            ptr <= '0;
            illegal <= 1'b0;
            bus_err <= 1'b0;
        end else begin
            if (wb_done) pend[wb_addr] <= 1'b0;
            if (dispatch) begin
                // x0 never waits on a write
                if (rd != '0) pend[rd] <= 1'b1;
                ptr <= (ptr == PW'(NB_LANE - 1)) ? '0 : ptr + 1'b1;
            end
            if (inst_valid && inst_err) bus_err <= 1'b1;
            if (inst_valid && !inst_err && drop) illegal <= 1'b1;
        end
    end

    assign issue_busy = |pend;

endmodule

`default_nettype wire

/* design/pipe_slice.sv */
// Valid/ready holding register

`timescale 1ns/1ps
`default_nettype none

module pipe_slice #(
    parameter type payload_t = logic
) (
    input  wire           aclk,
    input  wire           arst_n,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire           out_ready,
    output payload_t      out_data
);

    logic full;
    payload_t data_q;

    // Free slot, or the held entry leaves in this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data = data_q;

endmodule

`default_nettype wire

/* design/rv_int_core.sv */
// RV32I integer execution core

`timescale 1ns/1ps
`default_nettype none

module rv_int_core #(
    parameter int NB_LANE = 3,
    parameter logic [rv_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
    input  wire                                    aclk,
    input  wire                                    arst_n,
    output logic                                   imem_arvalid,
    input  wire                                    imem_arready,
    output logic [rv_pkg::XLEN-1:0]                imem_araddr,
    output logic [2:0]                             imem_arprot,
    input  wire                                    imem_rvalid,
    output logic                                   imem_rready,
    input  wire  [rv_pkg::ILEN-1:0]                imem_rdata,
    input  wire  [1:0]                             imem_rresp,
    output logic [rv_pkg::STATUS_W-1:0]            status,
    output logic [rv_pkg::REG_NB*rv_pkg::XLEN-1:0] dbg_regs
);

    import rv_pkg::*;

    ////////////////////
    // Internal links
    ////////////////////

    logic inst_valid, inst_ready, inst_err, fetch_busy;
    logic [ILEN-1:0] inst_data;
    logic [REG_AW-1:0] rs1_addr, rs2_addr, rd_addr, wb_addr;
    logic [XLEN-1:0] rs1_val, rs2_val, rd_val;
    logic rd_wr, wb_done, issue_busy, illegal, bus_err;
    logic [NB_LANE-1:0] lane_req_valid, lane_req_ready;
    logic [NB_LANE-1:0] lane_rsp_valid, lane_rsp_ready;
    lane_req_t [NB_LANE-1:0] lane_req;
    lane_rsp_t [NB_LANE-1:0] lane_rsp;

    inst_fetch #(.BOOT_ADDR(BOOT_ADDR)) inst_fetch_inst (
        .aclk, .arst_n,
        .imem_arvalid, .imem_arready, .imem_araddr, .imem_arprot,
        .imem_rvalid, .imem_rready, .imem_rdata, .imem_rresp,
        .inst_valid, .inst_ready, .inst_data, .inst_err, .fetch_busy
    );

    issue_unit #(.NB_LANE(NB_LANE)) issue_unit_inst (
        .aclk, .arst_n,
        .inst_valid, .inst_ready, .inst_data, .inst_err,
        .rs1_addr, .rs1_val, .rs2_addr, .rs2_val,
        .lane_req_valid, .lane_req_ready, .lane_req,
        .wb_done, .wb_addr, .issue_busy, .illegal, .bus_err
    );

    for (genvar i = 0; i < NB_LANE; i++) begin : g_lane
        alu_lane alu_lane_inst (
            .aclk      (aclk),
            .arst_n    (arst_n),
            .req_valid (lane_req_valid[i]),
            .req_ready (lane_req_ready[i]),
            .req       (lane_req[i]),
            .rsp_valid (lane_rsp_valid[i]),
            .rsp_ready (lane_rsp_ready[i]),
            .rsp       (lane_rsp[i])
        );
    end

    writeback_arbiter #(.NB_LANE(NB_LANE)) writeback_arbiter_inst (
        .aclk, .arst_n,
        .lane_rsp_valid, .lane_rsp_ready, .lane_rsp,
        .rd_wr, .rd_addr, .rd_val, .wb_done, .wb_addr
    );

    int_regfile int_regfile_inst (
        .aclk, .arst_n,
        .rs1_addr, .rs1_val, .rs2_addr, .rs2_val,
        .rd_wr, .rd_addr, .rd_val, .dbg_regs
    );

    // Busy covers fetch in flight and results not yet written back
    assign status[ST_BUSY] = fetch_busy || issue_busy;
    assign status[ST_ILLEGAL] = illegal;
    assign status[ST_BUS_ERR] = bus_err;

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
// RV32I integer core definitions

`default_nettype none

package rv_pkg;

    ////////////////////
    // Architecture sizes
    ////////////////////

    localparam int XLEN = 32;
    localparam int ILEN = 32;
    localparam int REG_NB = 32;
    localparam int REG_AW = 5;

    // Major opcodes, bits [6:0] of the instruction
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    ////////////////////
    // ALU operations
    ////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // Operand b straight to the result, used by LUI
        ALU_PASS_B
    } alu_op_e;

    ////////////////////
    // Lane payloads
    ////////////////////

    typedef struct packed {
        alu_op_e op;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0] opa;
        logic [XLEN-1:0] opb;
    } lane_req_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0] res;
    } lane_rsp_t;

    // Status port layout
    localparam int STATUS_W = 3;
    localparam int ST_BUSY = 0;
    localparam int ST_ILLEGAL = 1;
    localparam int ST_BUS_ERR = 2;

endpackage

`default_nettype wire

/* design/writeback_arbiter.sv */
// Round-robin write-back of lane results

`timescale 1ns/1ps
`default_nettype none

module writeback_arbiter #(
    parameter int NB_LANE = 3
) (
    input  wire                                aclk,
    input  wire                                arst_n,
    input  wire  [NB_LANE-1:0]                 lane_rsp_valid,
    output logic [NB_LANE-1:0]                 lane_rsp_ready,
    input  wire rv_pkg::lane_rsp_t [NB_LANE-1:0] lane_rsp,
    output logic                               rd_wr,
    output logic [rv_pkg::REG_AW-1:0]          rd_addr,
    output logic [rv_pkg::XLEN-1:0]            rd_val,
    output logic                               wb_done,
    output logic [rv_pkg::REG_AW-1:0]          wb_addr
);

    import rv_pkg::*;

    localparam int PW = (NB_LANE > 1) ? $clog2(NB_LANE) : 1;

    logic [PW-1:0] gp;
    logic [PW-1:0] sel;
    logic found;

    // First valid lane at or after the grant pointer
    always_comb begin
        int idx;
        found = 1'b0;
        sel = gp;
        for (int k = 0; k < NB_LANE; k++) begin
            idx = int'(gp) + k;
            if (idx >= NB_LANE) idx = idx - NB_LANE;
            if (!found && lane_rsp_valid[idx]) begin
                found = 1'b1;
                sel = PW'(idx);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NB_LANE; i++) begin
            lane_rsp_ready[i] = found && (sel == PW'(i));
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            gp <= '0;
        end else if (found) begin
            gp <= (sel == PW'(NB_LANE - 1)) ? '0 : sel + 1'b1;
        end
    end

    lane_rsp_t win;

    assign win = lane_rsp[sel];
    assign rd_wr = found;
    assign rd_addr = win.rd;
    assign rd_val = win.res;

    // Releases the scoreboard entry on the same edge as the write
    assign wb_done = found;
    assign wb_addr = win.rd;

endmodule

`default_nettype wire

/* rv_int_core.f */
design/rv_pkg.sv
design/pipe_slice.sv
design/inst_fetch.sv
design/issue_unit.sv
design/alu_lane.sv
design/writeback_arbiter.sv
design/int_regfile.sv
design/rv_int_core.sv
test/rv_int_core_tb.sv

/* test/rv_int_core_tb.sv */
// Testbench for the RV32I integer core

`timescale 1ns/1ps
`default_nettype none

module rv_int_core_tb;

    import rv_pkg::*;

    localparam int NB_LANE = 3;
    localparam logic [31:0] BOOT_ADDR = 32'h0000_0100;
    localparam logic [31:0] RNG_SEED = 32'h6a38;
    localparam logic [31:0] NOP = 32'h0000_0013;
    // AXI protection bits for a privileged secure instruction fetch
    localparam logic [2:0] ARPROT_FETCH = {1'b1, 1'b0, 1'b1};
    localparam int MEM_WORDS = 256;
    localparam int PAD_WORDS = 4;
    localparam int DELAY_NB = 512;
    localparam int N_IMM = 14;
    localparam int N_CHAIN = 12;
    localparam int N_RAND = 200;
    localparam int N_FAULT = 6;
    localparam int TIMEOUT_CYC = 40 * (N_IMM + N_CHAIN + N_RAND + N_FAULT) + 200;
    // Chain steps from the lowest field up are add sub xor or and sll srl sra slt sltu
    localparam logic [29:0] CHAIN_F3 = {3'd3, 3'd2, 3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd0, 3'd0};
    localparam logic [9:0] CHAIN_ALT = 10'b0010000010;

    logic aclk;
    logic arst_n;
    logic imem_arvalid;
    logic imem_arready;
    logic [31:0] imem_araddr;
    logic [2:0] imem_arprot;
    logic imem_rvalid;
    logic imem_rready;
    logic [31:0] imem_rdata;
    logic [1:0] imem_rresp;
    logic [STATUS_W-1:0] status;
    logic [REG_NB*XLEN-1:0] dbg_regs;

    logic [31:0] prog_mem [0:MEM_WORDS-1];
    logic prog_err [0:MEM_WORDS-1];
    int prog_len;
    int unsigned delay_tbl [0:DELAY_NB-1];
    int dly_idx = 0;
    logic [31:0] exp_regs [0:31];
    logic exp_illegal;
    logic exp_bus_err;
    logic [31:0] end_addr;
    logic ar_fire = 1'b0;
    logic r_fire = 1'b0;
    logic [31:0] ar_addr_q = '0;
    logic [31:0] next_addr = '0;
    logic ar_seen = 1'b0;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    event start_check;
    event check_done;

    rv_int_core #(
        .NB_LANE   (NB_LANE),
        .BOOT_ADDR (BOOT_ADDR)
    ) rv_int_core_inst (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_araddr  (imem_araddr),
        .imem_arprot  (imem_arprot),
        .imem_rvalid  (imem_rvalid),
        .imem_rready  (imem_rready),
        .imem_rdata   (imem_rdata),
        .imem_rresp   (imem_rresp),
        .status       (status),
        .dbg_regs     (dbg_regs)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    ////////////////////
    // Encoders and reference
    ////////////////////

    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic void put_word(input logic [31:0] w, input logic err);
        prog_mem[prog_len] = w;
        prog_err[prog_len] = err;
        prog_len++;
    endfunction

    // Result of one instruction from the RV32I definitions
    function automatic logic [31:0] ref_value(input logic [31:0] inst, input logic [31:0] a,
                                              input logic [31:0] rs2_v);
        logic [31:0] b;
        logic [4:0] sh;
        logic alt;
        alt = inst[30];
        if (inst[6:0] == 7'b0110111) return {inst[31:12], 12'h000};
        if (inst[6:0] == 7'b0110011) b = rs2_v;
        else b = {{20{inst[31]}}, inst[31:20]};
        sh = b[4:0];
        case (inst[14:12])
            3'd0: return (inst[6:0] == 7'b0110011 && alt) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh)) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void run_model();
        logic [31:0] w;
        logic [6:0] opc;
        for (int r = 0; r < 32; r++) exp_regs[r] = '0;
        exp_illegal = 1'b0;
        exp_bus_err = 1'b0;
        for (int i = 0; i < prog_len; i++) begin
            w = prog_mem[i];
            opc = w[6:0];
            if (prog_err[i]) begin
                exp_bus_err = 1'b1;
            end else if (opc != 7'b0110011 && opc != 7'b0010011 && opc != 7'b0110111) begin
                exp_illegal = 1'b1;
            end else if (w[11:7] != 5'd0) begin
                exp_regs[w[11:7]] = ref_value(w, exp_regs[w[19:15]], exp_regs[w[24:20]]);
            end
        end
    endfunction

    ////////////////////
    // Programs
    ////////////////////

    task automatic load_imm_program();
        put_word(imm_word(12'hffb, 5'd0, 3'd0, 5'd1), 1'b0);
        put_word(imm_word(12'h7ff, 5'd0, 3'd0, 5'd2), 1'b0);
        put_word(lui_word(20'habcde, 5'd3), 1'b0);
        put_word(imm_word({7'h20, 5'd2}, 5'd1, 3'd5, 5'd4), 1'b0);
        put_word(imm_word({7'h00, 5'd4}, 5'd1, 3'd5, 5'd5), 1'b0);
        put_word(imm_word(12'hfff, 5'd2, 3'd4, 5'd6), 1'b0);
        put_word(imm_word(12'h001, 5'd1, 3'd2, 5'd7), 1'b0);
        put_word(imm_word(12'h001, 5'd1, 3'd3, 5'd8), 1'b0);
        put_word(imm_word(12'h800, 5'd0, 3'd6, 5'd9), 1'b0);
        put_word(imm_word(12'hff0, 5'd3, 3'd7, 5'd10), 1'b0);
        put_word(imm_word({7'h00, 5'd20}, 5'd2, 3'd1, 5'd11), 1'b0);
        put_word(lui_word(20'h80000, 5'd12), 1'b0);
        put_word(imm_word(12'hfff, 5'd12, 3'd0, 5'd13), 1'b0);
        put_word(imm_word({7'h20, 5'd31}, 5'd12, 3'd5, 5'd14), 1'b0);
    endtask

    // Every step reads the destination of the step before
    task automatic load_chain_program();
        logic [4:0] rd;
        put_word(imm_word(12'h003, 5'd0, 3'd0, 5'd1), 1'b0);
        put_word(imm_word(12'hf9c, 5'd0, 3'd0, 5'd2), 1'b0);
        for (int k = 0; k < 10; k++) begin
            rd = 5'(3 + k);
            put_word(op_word(CHAIN_ALT[k] ? 7'h20 : 7'h00, 5'd1, rd - 5'd1,
                             CHAIN_F3[3*k +: 3], rd), 1'b0);
        end
    endtask

    task automatic load_random_program();
        int kind;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        for (int i = 0; i < N_RAND; i++) begin
            kind = $urandom_range(0, 2);
            rd = 5'($urandom_range(0, 31));
            rs1 = 5'($urandom_range(0, 31));
            rs2 = 5'($urandom_range(0, 31));
            f3 = 3'($urandom_range(0, 7));
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            case (kind)
                0: put_word(op_word(f7, rs2, rs1, f3, rd), 1'b0);
                1: begin
                    // Shift immediates keep their funct7 field legal
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {(f3 == 3'd5) ? f7 : 7'h00, rs2};
                    else imm = 12'($urandom);
                    put_word(imm_word(imm, rs1, f3, rd), 1'b0);
                end
                default: put_word(lui_word(20'($urandom), rd), 1'b0);
            endcase
        end
    endtask

    task automatic load_fault_program();
        put_word(imm_word(12'd5, 5'd0, 3'd0, 5'd1), 1'b0);
        put_word({12'h123, 5'd1, 3'b000, 5'd2, 7'b1111111}, 1'b0);
        put_word(imm_word(12'd1, 5'd1, 3'd0, 5'd3), 1'b0);
        put_word(imm_word(12'd99, 5'd0, 3'd0, 5'd4), 1'b1);
        put_word(op_word(7'h00, 5'd3, 5'd1, 3'd0, 5'd5), 1'b0);
        put_word(imm_word(12'hff9, 5'd5, 3'd0, 5'd6), 1'b0);
    endtask

    ////////////////////
    // Instruction memory
    ////////////////////

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - BOOT_ADDR) >> 2);
    endfunction

    function automatic int draw_delay();
        int d;
        d = int'(delay_tbl[dly_idx]);
        dly_idx = (dly_idx + 1) % DELAY_NB;
        return d;
    endfunction

    always @(posedge aclk) begin
        ar_fire <= imem_arvalid && imem_arready;
        r_fire <= imem_rvalid && imem_rready;
        if (imem_arvalid && imem_arready) ar_addr_q <= imem_araddr;
    end

    // Addresses past the padding are never granted and fetch parks there
    initial begin : imem_model
        int phase;
        int wait_cyc;
        int idx;
        phase = 0;
        wait_cyc = 0;
        forever begin
            @(negedge aclk);
            if (!arst_n) begin
                imem_arready = 1'b0;
                imem_rvalid = 1'b0;
                phase = 0;
                wait_cyc = 0;
            end else if (phase == 0) begin
                if (ar_fire) begin
                    imem_arready = 1'b0;
                    phase = 1;
                    wait_cyc = draw_delay();
                end else if (imem_arvalid && !imem_arready &&
                             word_index(imem_araddr) < prog_len + PAD_WORDS) begin
                    if (wait_cyc == 0) imem_arready = 1'b1;
                    else wait_cyc--;
                end
            end else if (r_fire) begin
                imem_rvalid = 1'b0;
                phase = 0;
                wait_cyc = draw_delay();
            end else if (!imem_rvalid) begin
                if (wait_cyc == 0) begin
                    idx = word_index(ar_addr_q);
                    imem_rvalid = 1'b1;
                    imem_rdata = (idx < prog_len) ? prog_mem[idx] : NOP;
                    imem_rresp = (idx < prog_len && prog_err[idx]) ? 2'b10 : 2'b00;
                end else begin
                    wait_cyc--;
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Fetch address order
    always @(posedge aclk) begin
        if (!arst_n) begin
            next_addr <= BOOT_ADDR;
            ar_seen <= 1'b0;
        end else begin
            assert (ar_seen || !imem_rready) else begin
                $display("ERR @%0t: rready high before the first address", $time);
                err_cnt++;
            end
            if (imem_arvalid && imem_arready) begin
                assert (imem_araddr == next_addr) else begin
                    $display("ERR @%0t: araddr %h, expected %h", $time, imem_araddr, next_addr);
                    err_cnt++;
                end
                assert (imem_arprot == ARPROT_FETCH) else begin
                    $display("ERR @%0t: arprot %b, expected %b", $time, imem_arprot,
                             ARPROT_FETCH);
                    err_cnt++;
                end
                next_addr <= next_addr + 32'd4;
                ar_seen <= 1'b1;
            end
        end
    end

    task automatic check_reset_state();
        assert (!imem_arvalid && !imem_rready) else begin
            $display("ERR @%0t: bus valid/ready high in reset", $time);
            err_cnt++;
        end
        assert (status == '0 && dbg_regs == '0) else begin
            $display("ERR @%0t: status %b or registers not cleared by reset", $time, status);
            err_cnt++;
        end
    endtask

    initial begin : compare_proc
        int idle;
        logic [STATUS_W-1:0] exp_status;
        forever begin
            @(start_check);
            idle = 0;
            while (idle < 8) begin
                @(negedge aclk);
                if (imem_araddr >= end_addr && !status[ST_BUSY]) idle++;
                else idle = 0;
            end
            for (int r = 0; r < 32; r++) begin
                assert (dbg_regs[r*XLEN +: XLEN] === exp_regs[r]) else begin
                    $display("ERR @%0t: x%0d is %h, expected %h", $time, r,
                             dbg_regs[r*XLEN +: XLEN], exp_regs[r]);
                    err_cnt++;
                end
            end
            exp_status = '0;
            exp_status[ST_ILLEGAL] = exp_illegal;
            exp_status[ST_BUS_ERR] = exp_bus_err;
            assert (status === exp_status) else begin
                $display("ERR @%0t: status %b, expected %b", $time, status, exp_status);
                err_cnt++;
            end
            -> check_done;
        end
    end

    task automatic run_test(input int id, input string name);
        int err_before;
        err_before = err_cnt;
        @(negedge aclk);
        arst_n = 1'b0;
        prog_len = 0;
        case (id)
            1: load_imm_program();
            2: load_chain_program();
            3: load_random_program();
            default: load_fault_program();
        endcase
        run_model();
        end_addr = BOOT_ADDR + 32'(prog_len * 4);
        repeat (10) @(negedge aclk);
        check_reset_state();
        arst_n = 1'b1;
        -> start_check;
        @(check_done);
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("Test %0d %s: ok", id, name);
        end else begin
            fail_cnt++;
            $display("Test %0d %s: %0d errors", id, name, err_cnt - err_before);
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the core stalled and never went idle", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        imem_arready = 1'b0;
        imem_rvalid = 1'b0;
        imem_rdata = '0;
        imem_rresp = 2'b00;
        delay_tbl[0] = $urandom(RNG_SEED) % 4;
        for (int i = 1; i < DELAY_NB; i++) delay_tbl[i] = $urandom_range(0, 3);
        run_test(1, "op-imm and lui");
        run_test(2, "dependent chain");
        run_test(3, "random program");
        run_test(4, "illegal and bus error");
        $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
